/* include/floor_logic_params.svh */
`ifndef FLOOR_LOGIC_PARAMS_SVH
`define FLOOR_LOGIC_PARAMS_SVH

////////////////////////////////////////////////////////////
// Building geometry
////////////////////////////////////////////////////////////

// Floors served, first floor is code 0
`define NUM_FLOORS 11

// Floor code and elevator state code widths
`define FLOOR_W 4
`define STATE_W 6

////////////////////////////////////////////////////////////
// Elevator state machine encoding
////////////////////////////////////////////////////////////

// State codes below this are the per-floor stop states
`define STOP_STATE_LIMIT 11

// Selector code shown while emergency is held
`define EMERGENCY_SELECT 4'hF

`endif

/* hdl/floor_logic_pkg.sv */
`default_nettype none

`include "floor_logic_params.svh"

package floor_logic_pkg;

    // Floor code, 0 is the first floor
    typedef logic [`FLOOR_W-1:0] floor_t;

    // State code of the external elevator FSM
    typedef logic [`STATE_W-1:0] elev_state_t;

    // One bit per floor, for buttons and lights
    typedef logic [`NUM_FLOORS-1:0] button_vec_t;

    // Request stack storage, slot view for push and flat view for clear
    typedef union packed {
        floor_t [`NUM_FLOORS-1:0]            slot;
        logic [`NUM_FLOORS*`FLOOR_W-1:0]     flat;
    } floor_stack_u;

endpackage

`default_nettype wire

/* hdl/request_latch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "floor_logic_params.svh"

module request_latch (
    input  wire                           clock,
    input  wire                           reset_n,
    input  wire floor_logic_pkg::button_vec_t floor_call_buttons,
    input  wire floor_logic_pkg::button_vec_t panel_buttons,
    input  wire floor_logic_pkg::floor_t  current_floor_state,
    input  wire                           flush,
    input  wire                           served,
    input  wire                           full,
    output logic                          push,
    output floor_logic_pkg::floor_t       push_floor,
    output floor_logic_pkg::button_vec_t  call_button_lights,
    output floor_logic_pkg::button_vec_t  panel_button_lights
);

    floor_logic_pkg::button_vec_t here_mask;
    floor_logic_pkg::button_vec_t panel_ok;
    floor_logic_pkg::button_vec_t call_ok;
    floor_logic_pkg::button_vec_t pick_mask;
    floor_logic_pkg::button_vec_t served_mask;
    floor_logic_pkg::floor_t      pick_floor;
    logic                         pick_valid;
    logic                         pick_panel;

    ////////////////////////////////////////////////////////////
    // Request arbitration
    ////////////////////////////////////////////////////////////

    // Car already at this floor, so its buttons are ignored
    assign here_mask = floor_logic_pkg::button_vec_t'(1) << current_floor_state;

    assign panel_ok = panel_buttons & ~panel_button_lights & ~here_mask;
    assign call_ok  = floor_call_buttons & ~call_button_lights & ~here_mask;

    // Scan from the top down so the lowest floor wins, panel scanned last
    always_comb begin
        pick_valid = 1'b0;
        pick_panel = 1'b0;
        pick_floor = '0;
        for (int i = `NUM_FLOORS - 1; i >= 0; i--) begin
            if (call_ok[i]) begin
                pick_valid = 1'b1;
                pick_floor = floor_logic_pkg::floor_t'(i);
            end
        end
        for (int i = `NUM_FLOORS - 1; i >= 0; i--) begin
            if (panel_ok[i]) begin
                pick_valid = 1'b1;
                pick_panel = 1'b1;
                pick_floor = floor_logic_pkg::floor_t'(i);
            end
        end
    end

    // Only accepted when the stack has room
    assign push       = pick_valid && !flush && !full;
    assign push_floor = pick_floor;

    ////////////////////////////////////////////////////////////
    // Request lights
    ////////////////////////////////////////////////////////////

    assign pick_mask   = push ? (floor_logic_pkg::button_vec_t'(1) << pick_floor) : '0;
    assign served_mask = served ? here_mask : '0;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_button_lights  <= '0;
            panel_button_lights <= '0;
        end else if (flush) begin
            call_button_lights  <= '0;
            panel_button_lights <= '0;
        end else begin
            call_button_lights  <= (call_button_lights & ~served_mask)
                                 | (pick_panel ? '0 : pick_mask);
            panel_button_lights <= (panel_button_lights & ~served_mask)
                                 | (pick_panel ? pick_mask : '0);
        end
    end

endmodule

`default_nettype wire

/* hdl/request_stack.sv */
`timescale 1ns/1ps
`default_nettype none

`include "floor_logic_params.svh"

module request_stack (
    input  wire                          clock,
    input  wire                          reset_n,
    input  wire                          flush,
    input  wire                          push,
    input  wire floor_logic_pkg::floor_t push_floor,
    input  wire                          pop,
    output floor_logic_pkg::floor_t      top_floor,
    output logic                         empty,
    output logic                         full
);

    localparam int DEPTH_W = $clog2(`NUM_FLOORS + 1);

    floor_logic_pkg::floor_stack_u stack_q;
    logic [DEPTH_W-1:0]            depth;
    logic [DEPTH_W-1:0]            wr_idx;

    ////////////////////////////////////////////////////////////
    // Occupancy
    ////////////////////////////////////////////////////////////

    assign empty = (depth == '0);
    assign full  = (depth == DEPTH_W'(`NUM_FLOORS));

    // Depth only moves on a lone push or a lone pop
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            depth <= '0;
        end else if (flush) begin
            depth <= '0;
        end else if (push && !pop) begin
            depth <= depth + 1'b1;
        end else if (pop && !push) begin
            depth <= depth - 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////

    // Push with pop overwrites the top slot in place
    assign wr_idx = pop ? depth - 1'b1 : depth;

    always_ff @(posedge clock) begin
        if (flush) begin
            stack_q.flat <= '0;
        end else if (push) begin
            stack_q.slot[wr_idx] <= push_floor;
        end
    end

    // Newest entry, first floor when nothing is queued
    assign top_floor = empty ? '0 : stack_q.slot[depth - 1'b1];

endmodule

`default_nettype wire

/* hdl/stop_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "floor_logic_params.svh"

module stop_dispatch (
    input  wire                              clock,
    input  wire                              reset_n,
    input  wire                              emergency_btn,
    input  wire                              power_switch,
    input  wire                              door_open_btn,
    input  wire                              door_close_btn,
    input  wire floor_logic_pkg::floor_t     current_floor_state,
    input  wire floor_logic_pkg::elev_state_t elevator_state,
    input  wire floor_logic_pkg::floor_t     top_floor,
    input  wire                              empty,
    output logic                             flush,
    output logic                             pop,
    output logic                             served,
    output floor_logic_pkg::floor_t          elevator_floor_selector,
    output logic                             direction_selector,
    output logic                             activate_elevator,
    output logic                             door_open_allowed,
    output logic                             door_close_allowed
);

    logic                    is_stop;
    logic                    at_target;
    logic                    ready;
    floor_logic_pkg::floor_t last_target;

    ////////////////////////////////////////////////////////////
    // State decode and flush
    ////////////////////////////////////////////////////////////

    // Stop states come first in the FSM encoding, one per floor
    assign is_stop = (elevator_state < `STOP_STATE_LIMIT);

    assign flush = !power_switch || emergency_btn;

    ////////////////////////////////////////////////////////////
    // Dispatch
    ////////////////////////////////////////////////////////////

    assign at_target = (top_floor == current_floor_state);
    assign ready     = !flush && !empty && is_stop;

    // Stopped away from the target, so send the car
    assign activate_elevator = ready && !at_target;

    // Stopped at the target, so retire the request
    assign pop    = ready && at_target;
    assign served = pop;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            direction_selector <= 1'b1;
            last_target        <= '0;
        end else begin
            if (activate_elevator) begin
                // Up when the target is above, down otherwise
                direction_selector <= (top_floor > current_floor_state);
            end
            if (!empty) begin
                last_target <= top_floor;
            end
        end
    end

    // Keep showing the last target once the stack drains
    always_comb begin
        if (emergency_btn) begin
            elevator_floor_selector = `EMERGENCY_SELECT;
        end else if (!empty) begin
            elevator_floor_selector = top_floor;
        end else begin
            elevator_floor_selector = last_target;
        end
    end

    ////////////////////////////////////////////////////////////
    // Doors
    ////////////////////////////////////////////////////////////

    assign door_open_allowed  = is_stop && power_switch && door_open_btn;
    assign door_close_allowed = is_stop && power_switch && door_close_btn;

endmodule

`default_nettype wire

/* hdl/floor_logic_control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module floor_logic_control_unit (
    input  wire                               clock,
    input  wire                               reset_n,
    input  wire floor_logic_pkg::button_vec_t floor_call_buttons,
    input  wire floor_logic_pkg::button_vec_t panel_buttons,
    input  wire                               door_open_btn,
    input  wire                               door_close_btn,
    input  wire                               emergency_btn,
    input  wire                               power_switch,
    input  wire floor_logic_pkg::floor_t      current_floor_state,
    input  wire floor_logic_pkg::elev_state_t elevator_state,
    output wire floor_logic_pkg::floor_t      elevator_floor_selector,
    output wire                               direction_selector,
    output wire                               activate_elevator,
    output wire floor_logic_pkg::button_vec_t call_button_lights,
    output wire floor_logic_pkg::button_vec_t panel_button_lights,
    output wire                               door_open_allowed,
    output wire                               door_close_allowed
);

    // Request path
    logic                    flush;
    logic                    push;
    floor_logic_pkg::floor_t push_floor;
    logic                    full;

    // Service path
    logic                    empty;
    floor_logic_pkg::floor_t top_floor;
    logic                    pop;
    logic                    served;

    request_latch u_request_latch (
        .clock               (clock),
        .reset_n             (reset_n),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .current_floor_state (current_floor_state),
        .flush               (flush),
        .served              (served),
        .full                (full),
        .push                (push),
        .push_floor          (push_floor),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights)
    );

    request_stack u_request_stack (
        .clock      (clock),
        .reset_n    (reset_n),
        .flush      (flush),
        .push       (push),
        .push_floor (push_floor),
        .pop        (pop),
        .top_floor  (top_floor),
        .empty      (empty),
        .full       (full)
    );

    stop_dispatch u_stop_dispatch (
        .clock                   (clock),
        .reset_n                 (reset_n),
        .emergency_btn           (emergency_btn),
        .power_switch            (power_switch),
        .door_open_btn           (door_open_btn),
        .door_close_btn          (door_close_btn),
        .current_floor_state     (current_floor_state),
        .elevator_state          (elevator_state),
        .top_floor               (top_floor),
        .empty                   (empty),
        .flush                   (flush),
        .pop                     (pop),
        .served                  (served),
        .elevator_floor_selector (elevator_floor_selector),
        .direction_selector      (direction_selector),
        .activate_elevator       (activate_elevator),
        .door_open_allowed       (door_open_allowed),
        .door_close_allowed      (door_close_allowed)
    );

endmodule

`default_nettype wire

/* bench/floor_logic_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "floor_logic_params.svh"

module floor_logic_checker (
    input wire                               clock,
    input wire                               reset_n,
    input wire                               flush,
    input wire                               push,
    input wire                               pop,
    input wire                               activate_elevator,
    input wire floor_logic_pkg::floor_t      elevator_floor_selector,
    input wire floor_logic_pkg::floor_t      current_floor_state,
    input wire floor_logic_pkg::elev_state_t elevator_state,
    input wire floor_logic_pkg::button_vec_t call_button_lights,
    input wire floor_logic_pkg::button_vec_t panel_button_lights,
    input wire                               door_open_btn,
    input wire                               door_open_allowed,
    input wire                               door_close_btn,
    input wire                               door_close_allowed
);

    int         fail_count = 0;
    logic [4:0] model_depth;
    logic       is_stop;

    assign is_stop = (elevator_state < `STOP_STATE_LIMIT);

    // Shadow of the request stack depth
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            model_depth <= '0;
        end else if (flush) begin
            model_depth <= '0;
        end else if (push && !pop) begin
            model_depth <= model_depth + 1'b1;
        end else if (pop && !push) begin
            model_depth <= model_depth - 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Dispatch and flush rules
    ////////////////////////////////////////////////////////////

    activate_off_target: assert property (@(posedge clock) disable iff (!reset_n)
        activate_elevator |-> (elevator_floor_selector != current_floor_state))
    else begin
        fail_count++;
        $error("activate_elevator high while the car is at the selected floor");
    end

    flush_clears_lights: assert property (@(posedge clock) disable iff (!reset_n)
        flush |=> (call_button_lights == '0 && panel_button_lights == '0))
    else begin
        fail_count++;
        $error("request lights still on one cycle after flush");
    end

    door_needs_stop: assert property (@(posedge clock) disable iff (!reset_n)
        (door_open_allowed -> (door_open_btn && is_stop))
        && (door_close_allowed -> (door_close_btn && is_stop)))
    else begin
        fail_count++;
        $error("door allowed without its button or outside a stop state");
    end

    ////////////////////////////////////////////////////////////
    // Stack capacity rules
    ////////////////////////////////////////////////////////////

    depth_in_range: assert property (@(posedge clock) disable iff (!reset_n)
        model_depth <= `NUM_FLOORS)
    else begin
        fail_count++;
        $error("request stack depth above eleven");
    end

    no_light_when_full: assert property (@(posedge clock) disable iff (!reset_n)
        (model_depth == `NUM_FLOORS) |=>
            ((call_button_lights & ~$past(call_button_lights)) == '0)
            && ((panel_button_lights & ~$past(panel_button_lights)) == '0))
    else begin
        fail_count++;
        $error("a request light rose while the stack was full");
    end

endmodule

bind floor_logic_control_unit floor_logic_checker u_checker (.*);

`default_nettype wire

/* bench/floor_logic_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "floor_logic_params.svh"

module floor_logic_tb;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 2;
    localparam int NUM_TESTS    = 6;
    localparam int TEST_CYCLES  = 40;
    localparam int TIMEOUT_NS   = (RESET_CYCLES + NUM_TESTS * TEST_CYCLES + 20) * CLK_PERIOD;
    localparam floor_logic_pkg::elev_state_t MOVING_STATE = 6'd20;

    logic                         clock;
    logic                         reset_n;
    floor_logic_pkg::button_vec_t floor_call_buttons;
    floor_logic_pkg::button_vec_t panel_buttons;
    logic                         door_open_btn;
    logic                         door_close_btn;
    logic                         emergency_btn;
    logic                         power_switch;
    floor_logic_pkg::floor_t      current_floor_state;
    floor_logic_pkg::elev_state_t elevator_state;
    floor_logic_pkg::floor_t      elevator_floor_selector;
    logic                         direction_selector;
    logic                         activate_elevator;
    floor_logic_pkg::button_vec_t call_button_lights;
    floor_logic_pkg::button_vec_t panel_button_lights;
    logic                         door_open_allowed;
    logic                         door_close_allowed;

    integer seed = 32'hd364_f395;
    int     check_count = 0;
    int     error_count = 0;
    int     test_start_errors = 0;

    floor_logic_control_unit u_dut (.*);

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Error: run did not finish within %0d ns", TIMEOUT_NS);
        $display(">>> FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic floor_logic_pkg::button_vec_t floor_bit(input int f);
        return floor_logic_pkg::button_vec_t'(1) << f;
    endfunction

    task automatic check_value(input string name, input logic [15:0] actual,
                               input logic [15:0] expected);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("Error at %0d ns: %s expected 'h%0h, got 'h%0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_lights(input logic [15:0] panel, input logic [15:0] call);
        check_value("panel_button_lights", panel_button_lights, panel);
        check_value("call_button_lights", call_button_lights, call);
    endtask

    task automatic start_test();
        test_start_errors = error_count;
    endtask

    task automatic finish_test(input int num, input string name);
        $display("Test %0d %s: %s", num, name,
                 (error_count == test_start_errors) ? "passed" : "failed");
    endtask

    // Capture edge, then sample mid-cycle
    task automatic next_sample();
        @(posedge clock);
        @(negedge clock);
    endtask

    // One-cycle press, returns after the edge that takes it
    task automatic press_once(input floor_logic_pkg::button_vec_t panel,
                              input floor_logic_pkg::button_vec_t call);
        @(posedge clock);
        panel_buttons      <= panel;
        floor_call_buttons <= call;
        @(posedge clock);
        panel_buttons      <= '0;
        floor_call_buttons <= '0;
        @(negedge clock);
    endtask

    task automatic set_car(input floor_logic_pkg::floor_t f,
                           input floor_logic_pkg::elev_state_t s);
        @(posedge clock);
        current_floor_state <= f;
        elevator_state      <= s;
    endtask

    task automatic hold_cycles();
        int n;
        n = 1 + ($unsigned($random(seed)) % 3);
        repeat (n) @(posedge clock);
    endtask

    // Short power-off pulse empties stack and lights
    task automatic clear_requests();
        @(posedge clock);
        power_switch <= 1'b0;
        @(posedge clock);
        power_switch <= 1'b1;
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        reset_n             <= 1'b0;
        floor_call_buttons  <= '0;
        panel_buttons       <= '0;
        door_open_btn       <= 1'b0;
        door_close_btn      <= 1'b0;
        emergency_btn       <= 1'b0;
        power_switch        <= 1'b1;
        current_floor_state <= '0;
        elevator_state      <= '0;
        repeat (RESET_CYCLES) @(posedge clock);
        reset_n <= 1'b1;

        start_test();
        press_once(floor_bit(5), '0);
        check_lights(floor_bit(5), 0);
        check_value("elevator_floor_selector", elevator_floor_selector, 5);
        check_value("activate_elevator", activate_elevator, 1);
        next_sample();
        check_value("direction_selector", direction_selector, 1);
        set_car(5, 5);
        next_sample();
        check_lights(0, 0);
        // Drained stack keeps showing the floor just served
        check_value("elevator_floor_selector", elevator_floor_selector, 5);
        finish_test(1, "dispatch up");

        // Car at floor 5, its own buttons are refused
        start_test();
        @(posedge clock);
        panel_buttons      <= floor_bit(5);
        floor_call_buttons <= floor_bit(5);
        @(posedge clock);
        panel_buttons      <= floor_bit(3);
        floor_call_buttons <= floor_bit(6);
        @(negedge clock);
        check_lights(0, 0);
        next_sample();
        check_lights(floor_bit(3), 0);
        next_sample();
        check_lights(floor_bit(3), floor_bit(6));
        hold_cycles();
        panel_buttons      <= '0;
        floor_call_buttons <= '0;
        @(negedge clock);
        check_lights(floor_bit(3), floor_bit(6));
        clear_requests();
        finish_test(2, "arbitration");

        start_test();
        set_car(5, MOVING_STATE);
        press_once(floor_bit(2), '0);
        press_once(floor_bit(7), '0);
        check_value("activate_elevator", activate_elevator, 0);
        check_value("elevator_floor_selector", elevator_floor_selector, 7);
        set_car(5, 5);
        @(negedge clock);
        check_value("activate_elevator", activate_elevator, 1);
        set_car(7, 7);
        next_sample();
        check_lights(floor_bit(2), 0);
        check_value("elevator_floor_selector", elevator_floor_selector, 2);
        next_sample();
        check_value("direction_selector", direction_selector, 0);
        finish_test(3, "stack order");

        start_test();
        press_once('0, floor_bit(9));
        @(posedge clock);
        emergency_btn <= 1'b1;
        @(negedge clock);
        check_value("elevator_floor_selector", elevator_floor_selector, `EMERGENCY_SELECT);
        check_value("activate_elevator", activate_elevator, 0);
        next_sample();
        check_lights(0, 0);
        @(posedge clock);
        emergency_btn <= 1'b0;
        press_once(floor_bit(4), '0);
        check_value("activate_elevator", activate_elevator, 1);
        @(posedge clock);
        power_switch <= 1'b0;
        next_sample();
        check_lights(0, 0);
        check_value("activate_elevator", activate_elevator, 0);
        press_once(floor_bit(3), '0);
        check_lights(0, 0);
        @(posedge clock);
        power_switch <= 1'b1;
        finish_test(4, "flush");

        start_test();
        @(posedge clock);
        door_open_btn <= 1'b1;
        @(negedge clock);
        check_value("door_open_allowed", door_open_allowed, 1);
        check_value("door_close_allowed", door_close_allowed, 0);
        set_car(7, MOVING_STATE);
        @(negedge clock);
        check_value("door_open_allowed", door_open_allowed, 0);
        set_car(7, 7);
        power_switch <= 1'b0;
        @(negedge clock);
        check_value("door_open_allowed", door_open_allowed, 0);
        @(posedge clock);
        power_switch   <= 1'b1;
        door_open_btn  <= 1'b0;
        door_close_btn <= 1'b1;
        @(negedge clock);
        check_value("door_close_allowed", door_close_allowed, 1);
        check_value("door_open_allowed", door_open_allowed, 0);
        @(posedge clock);
        door_close_btn <= 1'b0;
        finish_test(5, "doors");

        // Ten panel requests and call 1 fill the stack
        start_test();
        set_car(0, MOVING_STATE);
        @(posedge clock);
        panel_buttons      <= '1;
        floor_call_buttons <= '1;
        repeat (`NUM_FLOORS) @(posedge clock);
        hold_cycles();
        @(negedge clock);
        check_lights(16'h07FE, 16'h0002);
        set_car(1, 1);
        next_sample();
        check_lights(16'h07FC, 0);
        next_sample();
        check_lights(16'h07FD, 0);
        next_sample();
        check_lights(16'h07FD, 0);
        @(posedge clock);
        panel_buttons      <= '0;
        floor_call_buttons <= '0;
        clear_requests();
        finish_test(6, "full stack");

        repeat (3) @(posedge clock);
        $display("Summary: %0d checks, %0d errors, %0d assertion failures",
                 check_count, error_count, u_dut.u_checker.fail_count);
        if (error_count == 0 && u_dut.u_checker.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* floor_logic.f */
+incdir+include
hdl/floor_logic_pkg.sv
hdl/request_latch.sv
hdl/request_stack.sv
hdl/stop_dispatch.sv
hdl/floor_logic_control_unit.sv
bench/floor_logic_checker.sv
bench/floor_logic_tb.sv

/* Bender.yml */
package:
  name: floor_logic

sources:
  - include_dirs:
      - include
    files:
      - hdl/floor_logic_pkg.sv
      - hdl/request_latch.sv
      - hdl/request_stack.sv
      - hdl/stop_dispatch.sv
      - hdl/floor_logic_control_unit.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/floor_logic_checker.sv
      - bench/floor_logic_tb.sv
